// ==== include/yWriteBack_cfg.svh ====
`ifndef YWRITEBACK_CFG_SVH
`define YWRITEBACK_CFG_SVH

// row layout of the Y matrix memory
`define ROW_BITS 256
`define SLOT_BITS 64    // slot pitch inside a row
`define ENTRY_BITS 48   // 24 bit real, 24 bit imaginary
`define SLOTS 4

// row addressing
`define ADDR_BITS 11
`define PARKED_ADDR {`ADDR_BITS{1'b1}}   // driven while nothing is fetched

`endif

// ==== rtl/yRowPkg.sv ====
`include "yWriteBack_cfg.svh"

package yRowPkg;

   typedef logic [`ROW_BITS-1:0] rowData;       // one memory row
   typedef logic [`ENTRY_BITS-1:0] yEntry;      // {real, imag}
   typedef logic [`ADDR_BITS-1:0] rowAddr;
   typedef logic [`SLOTS-1:0] slotOneHot;       // slot selector as delivered
   typedef logic [$clog2(`SLOTS)-1:0] slotIndex;

endpackage

// ==== rtl/yCtrlPkg.sv ====
package yCtrlPkg;

   typedef enum logic [1:0]
   {
      IDLE,
      FETCH,
      MERGE,
      STORE
   } seqState;

   typedef enum logic [1:0]
   {
      NONE,
      MERGE_BOTH,    // both entries in one row
      MERGE_SPLIT,   // diagonal row now, non-diagonal row held
      WRITE_HELD
   } mergeStep;

   typedef logic setSel;   // 0 is set 1, 1 is set 2

endpackage

// ==== rtl/updateIf.sv ====
`timescale 1ns/1ps

interface updateIf;

   yRowPkg::rowAddr diagRow;
   yRowPkg::rowAddr nonDiagRow;
   yRowPkg::slotIndex diagIdx;
   yRowPkg::slotIndex nonDiagIdx;
   logic slotsLegal;                 // both codes one-hot and not colliding
   logic sameRow;
   yRowPkg::yEntry diagValue;
   yRowPkg::yEntry changeValue;

   modport decoder
   (
      output diagRow, nonDiagRow, diagIdx, nonDiagIdx,
      output slotsLegal, sameRow, diagValue, changeValue
   );

   modport sequencer
   (
      input diagRow, nonDiagRow, sameRow
   );

   modport merger
   (
      input diagRow, nonDiagRow, diagIdx, nonDiagIdx,
      input slotsLegal, diagValue, changeValue
   );

endinterface

// ==== rtl/updateDecode.sv ====
`timescale 1ns/1ps
`include "yWriteBack_cfg.svh"

module updateDecode
(
   input logic clock,
   input logic reset,
   input logic dpDone,
   input logic cpDone,
   input yRowPkg::rowAddr diagAddr,
   input yRowPkg::rowAddr nonDiagAddr,
   input yRowPkg::slotOneHot diagSlot,
   input yRowPkg::slotOneHot nonDiagSlot,
   input yRowPkg::yEntry computedDiag,
   input yRowPkg::yEntry changeData,
   input yCtrlPkg::setSel setSelect,
   input logic idle,
   updateIf.decoder upd
);

   yRowPkg::rowAddr diagRowQ [2];
   yRowPkg::rowAddr nonDiagRowQ [2];
   yRowPkg::slotOneHot diagSlotQ [2];
   yRowPkg::slotOneHot nonDiagSlotQ [2];
   yRowPkg::yEntry diagValueQ [2];
   yRowPkg::yEntry changeValueQ [2];
   yRowPkg::slotOneHot diagSlotSel;
   yRowPkg::slotOneHot nonDiagSlotSel;
   logic capture;
   yCtrlPkg::setSel captureSet;

   function automatic yRowPkg::slotIndex encodeSlot(input yRowPkg::slotOneHot code);
      yRowPkg::slotIndex idx;
      idx = '0;
      for (int k = 0; k < `SLOTS; k++)
         if (code[k])
            idx = yRowPkg::slotIndex'(k);
      return idx;
   endfunction

   assign capture = idle && dpDone;   // busy unit ignores done flags
   assign captureSet = cpDone;        // dp alone is set 1, dp with cp is set 2

   always_ff @(posedge clock)
   begin
      if (!reset)
      begin
         diagSlotQ[0] <= '0;
         diagSlotQ[1] <= '0;
         nonDiagSlotQ[0] <= '0;
         nonDiagSlotQ[1] <= '0;
      end
      else if (capture)
      begin
         diagSlotQ[captureSet] <= diagSlot;
         nonDiagSlotQ[captureSet] <= nonDiagSlot;
      end
   end

   always_ff @(posedge clock)
   begin
      if (capture)
      begin
         diagRowQ[captureSet] <= diagAddr;
         nonDiagRowQ[captureSet] <= nonDiagAddr;
         diagValueQ[captureSet] <= computedDiag;
         changeValueQ[captureSet] <= changeData;
      end
   end

   assign diagSlotSel = diagSlotQ[setSelect];
   assign nonDiagSlotSel = nonDiagSlotQ[setSelect];

   assign upd.diagRow = diagRowQ[setSelect];
   assign upd.nonDiagRow = nonDiagRowQ[setSelect];
   assign upd.diagValue = diagValueQ[setSelect];
   assign upd.changeValue = changeValueQ[setSelect];
   assign upd.diagIdx = encodeSlot(diagSlotSel);
   assign upd.nonDiagIdx = encodeSlot(nonDiagSlotSel);
   assign upd.sameRow = (diagRowQ[setSelect] == nonDiagRowQ[setSelect]);

   // same slot twice only collides when both entries share a row
   assign upd.slotsLegal = $onehot(diagSlotSel) && $onehot(nonDiagSlotSel)
      && !(upd.sameRow && (diagSlotSel == nonDiagSlotSel));

endmodule

// ==== rtl/writeBackSequencer.sv ====
`timescale 1ns/1ps
`include "yWriteBack_cfg.svh"

module writeBackSequencer
(
   input logic clock,
   input logic reset,
   input logic dpDone,
   input logic cpDone,
   updateIf.sequencer upd,
   output yCtrlPkg::setSel setSelect,
   output logic idle,
   output yCtrlPkg::mergeStep step,
   output yRowPkg::rowAddr readAddr1,
   output yRowPkg::rowAddr readAddr2,
   output logic writeDone
);

   yCtrlPkg::seqState state;
   yCtrlPkg::seqState nextState;
   yCtrlPkg::setSel secondSet;    // set 2 in progress
   yRowPkg::rowAddr nextAddr1;    // set 2 read addresses
   yRowPkg::rowAddr nextAddr2;
   yRowPkg::rowAddr secondRead;
   logic lastWrite;

   assign idle = (state == yCtrlPkg::IDLE);

   // The merger only looks at the selected set in MERGE and STORE, so set 2
   // is shown during set 1 FETCH and its addresses are kept for later.
   assign setSelect = (state == yCtrlPkg::FETCH) ? 1'b1 : secondSet;

   assign secondRead = upd.sameRow ? `PARKED_ADDR : upd.nonDiagRow;   // one row suffices
   assign lastWrite = secondSet && ((state == yCtrlPkg::MERGE && upd.sameRow)
      || state == yCtrlPkg::STORE);

   always_comb
   begin
      nextState = state;
      case (state)
         yCtrlPkg::IDLE:
            if (dpDone && cpDone)
               nextState = yCtrlPkg::FETCH;
         yCtrlPkg::FETCH:
            nextState = yCtrlPkg::MERGE;
         yCtrlPkg::MERGE:
            if (!upd.sameRow)
               nextState = yCtrlPkg::STORE;
            else
               nextState = secondSet ? yCtrlPkg::IDLE : yCtrlPkg::FETCH;
         default:
            nextState = secondSet ? yCtrlPkg::IDLE : yCtrlPkg::FETCH;
      endcase
   end

   always_comb
   begin
      case (state)
         yCtrlPkg::MERGE:
            step = upd.sameRow ? yCtrlPkg::MERGE_BOTH : yCtrlPkg::MERGE_SPLIT;
         yCtrlPkg::STORE:
            step = yCtrlPkg::WRITE_HELD;
         default:
            step = yCtrlPkg::NONE;
      endcase
   end

   always_ff @(posedge clock)
   begin
      if (!reset)
      begin
         state <= yCtrlPkg::IDLE;
         secondSet <= 1'b0;
         readAddr1 <= `PARKED_ADDR;
         readAddr2 <= `PARKED_ADDR;
         writeDone <= 1'b0;
      end
      else
      begin
         state <= nextState;
         writeDone <= lastWrite;          // lines up with the registered write
         readAddr1 <= `PARKED_ADDR;
         readAddr2 <= `PARKED_ADDR;
         if (state == yCtrlPkg::IDLE && nextState == yCtrlPkg::FETCH)
         begin
            readAddr1 <= upd.diagRow;     // set 1 is selected while idle
            readAddr2 <= secondRead;
         end
         else if (nextState == yCtrlPkg::FETCH)
         begin
            readAddr1 <= nextAddr1;
            readAddr2 <= nextAddr2;
            secondSet <= 1'b1;
         end
         if (nextState == yCtrlPkg::IDLE)
            secondSet <= 1'b0;
      end
   end

   always_ff @(posedge clock)
   begin
      if (state == yCtrlPkg::FETCH && !secondSet)
      begin
         nextAddr1 <= upd.diagRow;
         nextAddr2 <= secondRead;
      end
   end

endmodule

// ==== rtl/rowMerge.sv ====
`timescale 1ns/1ps
`include "yWriteBack_cfg.svh"

module rowMerge
(
   input logic clock,
   input logic reset,
   updateIf.merger upd,
   input yCtrlPkg::mergeStep step,
   input yRowPkg::rowData readData1,
   input yRowPkg::rowData readData2,
   output logic writeEnable,
   output yRowPkg::rowAddr writeAddr,
   output yRowPkg::rowData writeData
);

   yRowPkg::rowData diagMerged;      // readData1 with the diagonal value
   yRowPkg::rowData bothMerged;      // readData1 with both values
   yRowPkg::rowData nonDiagMerged;   // readData2 with the change value
   yRowPkg::rowData heldRow;

   // overwrites the low entry bits of one slot and keeps its upper bits
   function automatic yRowPkg::rowData insertEntry
   (
      input yRowPkg::rowData row,
      input yRowPkg::slotIndex idx,
      input yRowPkg::yEntry entry
   );
      yRowPkg::rowData merged;
      merged = row;
      merged[idx * `SLOT_BITS +: `ENTRY_BITS] = entry;
      return merged;
   endfunction

   always_comb
   begin
      if (upd.slotsLegal)
      begin
         diagMerged = insertEntry(readData1, upd.diagIdx, upd.diagValue);
         bothMerged = insertEntry(diagMerged, upd.nonDiagIdx, upd.changeValue);
         nonDiagMerged = insertEntry(readData2, upd.nonDiagIdx, upd.changeValue);
      end
      else
      begin
         diagMerged = '0;   // bad slot code clears the row
         bothMerged = '0;
         nonDiagMerged = '0;
      end
   end

   always_ff @(posedge clock)
   begin
      if (step == yCtrlPkg::MERGE_SPLIT)
         heldRow <= nonDiagMerged;   // written one cycle after the diagonal row
   end

   always_ff @(posedge clock)
   begin
      if (!reset)
      begin
         writeEnable <= 1'b0;
         writeAddr <= `PARKED_ADDR;
         writeData <= '0;
      end
      else
      begin
         case (step)
            yCtrlPkg::MERGE_BOTH:
            begin
               writeEnable <= 1'b1;
               writeAddr <= upd.diagRow;
               writeData <= bothMerged;
            end
            yCtrlPkg::MERGE_SPLIT:
            begin
               writeEnable <= 1'b1;
               writeAddr <= upd.diagRow;
               writeData <= diagMerged;
            end
            yCtrlPkg::WRITE_HELD:
            begin
               writeEnable <= 1'b1;
               writeAddr <= upd.nonDiagRow;
               writeData <= heldRow;
            end
            default:
            begin
               writeEnable <= 1'b0;
               writeAddr <= `PARKED_ADDR;
               writeData <= '0;
            end
         endcase
      end
   end

endmodule

// ==== rtl/yWriteBack.sv ====
`timescale 1ns/1ps

module yWriteBack
(
   input logic clock,
   input logic reset,
   input logic dpDone,
   input logic cpDone,
   input yRowPkg::rowAddr diagAddr,
   input yRowPkg::rowAddr nonDiagAddr,
   input yRowPkg::slotOneHot diagSlot,
   input yRowPkg::slotOneHot nonDiagSlot,
   input yRowPkg::yEntry computedDiag,
   input yRowPkg::yEntry changeData,
   input yRowPkg::rowData readData1,
   input yRowPkg::rowData readData2,
   output yRowPkg::rowAddr readAddr1,
   output yRowPkg::rowAddr readAddr2,
   output yRowPkg::rowAddr writeAddr,
   output yRowPkg::rowData writeData,
   output logic writeEnable,
   output logic writeDone
);

   yCtrlPkg::setSel setSelect;
   yCtrlPkg::mergeStep step;
   logic idle;

   updateIf upd ();   // selected update set

   updateDecode decode0
   (
      .clock(clock),
      .reset(reset),
      .dpDone(dpDone),
      .cpDone(cpDone),
      .diagAddr(diagAddr),
      .nonDiagAddr(nonDiagAddr),
      .diagSlot(diagSlot),
      .nonDiagSlot(nonDiagSlot),
      .computedDiag(computedDiag),
      .changeData(changeData),
      .setSelect(setSelect),
      .idle(idle),
      .upd(upd.decoder)
   );

   writeBackSequencer sequencer0
   (
      .clock(clock),
      .reset(reset),
      .dpDone(dpDone),
      .cpDone(cpDone),
      .upd(upd.sequencer),
      .setSelect(setSelect),
      .idle(idle),
      .step(step),
      .readAddr1(readAddr1),
      .readAddr2(readAddr2),
      .writeDone(writeDone)
   );

   rowMerge merge0
   (
      .clock(clock),
      .reset(reset),
      .upd(upd.merger),
      .step(step),
      .readData1(readData1),
      .readData2(readData2),
      .writeEnable(writeEnable),
      .writeAddr(writeAddr),
      .writeData(writeData)
   );

endmodule

// ==== verification/yWriteBack_chk.sv ====
`timescale 1ns/1ps
`include "yWriteBack_cfg.svh"

module yWriteBack_chk
(
   input logic clock,
   input logic reset,
   input logic writeEnable,
   input logic writeDone,
   input yRowPkg::rowAddr readAddr1
);

   int failures = 0;

   doneWithWrite: assert property (@(posedge clock) disable iff (!reset)
      writeDone |-> writeEnable)
   else
   begin
      failures++;
      $error("writeDone raised without writeEnable");
   end

   // fetch address lives for one cycle only
   singleFetch: assert property (@(posedge clock) disable iff (!reset)
      (readAddr1 != `PARKED_ADDR) |=> (readAddr1 == `PARKED_ADDR))
   else
   begin
      failures++;
      $error("readAddr1 held off the parked row for more than one cycle");
   end

   quietInReset: assert property (@(posedge clock) !reset |=> !writeEnable)
   else
   begin
      failures++;
      $error("writeEnable high during reset");
   end

endmodule

// ==== verification/yWriteBackTb.sv ====
`timescale 1ns/1ps
`include "yWriteBack_cfg.svh"

module yWriteBackTb;

   localparam int randomPairs = 20;
   localparam int numTests = randomPairs + 4;   // four directed pairs first
   localparam yRowPkg::rowAddr parked = `PARKED_ADDR;

   logic clock;
   logic reset;
   logic dpDone;
   logic cpDone;
   yRowPkg::rowAddr diagAddr;
   yRowPkg::rowAddr nonDiagAddr;
   yRowPkg::slotOneHot diagSlot;
   yRowPkg::slotOneHot nonDiagSlot;
   yRowPkg::yEntry computedDiag;
   yRowPkg::yEntry changeData;
   yRowPkg::rowData readData1;
   yRowPkg::rowData readData2;
   yRowPkg::rowAddr readAddr1;
   yRowPkg::rowAddr readAddr2;
   yRowPkg::rowAddr writeAddr;
   yRowPkg::rowData writeData;
   logic writeEnable;
   logic writeDone;

   yRowPkg::rowData mem [1 << `ADDR_BITS];      // memory seen by the DUT
   yRowPkg::rowData shadow [1 << `ADDR_BITS];   // expected contents
   yRowPkg::rowAddr expAddr [$];
   yRowPkg::rowData expData [$];
   logic expDone [$];
   int valueErrors = 0;
   int otherErrors = 0;
   int donePulses = 0;

   yWriteBack dut0 (.*);

   bind yWriteBack yWriteBack_chk chk0 (.*);

   initial
   begin
      clock = 1'b0;
      forever #50 clock = ~clock;
   end

   // one cycle read that already sees a write of the same cycle
   always @(posedge clock)
   begin
      if (writeEnable === 1'b1)
         mem[writeAddr] = writeData;
      readData1 <= mem[readAddr1];
      readData2 <= mem[readAddr2];
   end

   always @(negedge clock)
   begin
      if (reset && writeEnable === 1'b1)
      begin
         if (expAddr.size() == 0)
         begin
            $display("unexpected write to row %h while no write was pending", writeAddr);
            otherErrors++;
         end
         else
         begin
            checkAddr("writeAddr", writeAddr, expAddr.pop_front());
            checkRow("writeData", writeData, expData.pop_front());
            checkFlag("writeDone", writeDone, expDone.pop_front());
         end
      end
      if (reset && writeDone === 1'b1)
         donePulses++;
   end

   initial
   begin
      repeat (numTests * 12 + 50) @(posedge clock);
      $display("timeout, the write-back did not finish in time");
      $display("value errors %0d, other errors %0d", valueErrors, otherErrors + 1);
      $display(">>> FAIL");
      $finish;
   end

   function automatic yRowPkg::rowData fillRow(input int addr);
      yRowPkg::rowData row;
      for (int w = 0; w < 8; w++)
         row[32 * w +: 32] = (addr * 8 + w + 1) * 32'h9e3779b1;
      return row;
   endfunction

   // entry goes in the low bits of its slot and the slot tops are kept
   function automatic yRowPkg::rowData mergeRow(input yRowPkg::rowData row,
      input yRowPkg::slotOneHot slotA, input yRowPkg::slotOneHot slotB,
      input yRowPkg::yEntry entryA, input yRowPkg::yEntry entryB);
      yRowPkg::rowData result;
      result = row;
      for (int k = 0; k < `SLOTS; k++)
      begin
         if (slotA[k])
            result[k * `SLOT_BITS +: `ENTRY_BITS] = entryA;
         if (slotB[k])
            result[k * `SLOT_BITS +: `ENTRY_BITS] = entryB;
      end
      return result;
   endfunction

   function automatic bit slotsOk(input yRowPkg::slotOneHot ds,
      input yRowPkg::slotOneHot ns, input bit same);
      return $onehot(ds) && $onehot(ns) && !(same && ds == ns);
   endfunction

   function automatic yRowPkg::rowAddr randAddr();
      return yRowPkg::rowAddr'($urandom % 2047);   // keeps clear of the parked row
   endfunction

   function automatic yRowPkg::slotOneHot randSlot();
      if ($urandom % 8 == 0)
         return yRowPkg::slotOneHot'($urandom);   // may be zero or multi-hot
      return yRowPkg::slotOneHot'(1 << ($urandom % `SLOTS));
   endfunction

   function automatic yRowPkg::yEntry randEntry();
      return yRowPkg::yEntry'({$urandom, $urandom});
   endfunction

   task automatic checkRow(input string name, input yRowPkg::rowData got,
      input yRowPkg::rowData exp);
      if (got !== exp)
      begin
         $display("ERR %s got %h expected %h", name, got, exp);
         valueErrors++;
      end
   endtask

   task automatic checkAddr(input string name, input yRowPkg::rowAddr got,
      input yRowPkg::rowAddr exp);
      if (got !== exp)
      begin
         $display("ERR %s got %h expected %h", name, got, exp);
         valueErrors++;
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("ERR %s got %h expected %h", name, got, exp);
         valueErrors++;
      end
   endtask

   task automatic expectWrite(input yRowPkg::rowAddr addr, input yRowPkg::rowData data,
      input logic done);
      expAddr.push_back(addr);
      expData.push_back(data);
      expDone.push_back(done);
   endtask

   task automatic expectSet(input yRowPkg::rowAddr d, input yRowPkg::rowAddr n,
      input yRowPkg::slotOneHot ds, input yRowPkg::slotOneHot ns,
      input yRowPkg::yEntry dv, input yRowPkg::yEntry cv, input bit last);
      bit legal;
      legal = slotsOk(ds, ns, d == n);
      if (d == n)
      begin
         shadow[d] = legal ? mergeRow(shadow[d], ds, ns, dv, cv) : '0;
         expectWrite(d, shadow[d], last);
      end
      else
      begin
         shadow[d] = legal ? mergeRow(shadow[d], ds, '0, dv, cv) : '0;
         shadow[n] = legal ? mergeRow(shadow[n], '0, ns, dv, cv) : '0;
         expectWrite(d, shadow[d], 1'b0);   // diagonal row first
         expectWrite(n, shadow[n], last);
      end
   endtask

   task automatic applySet(input bit second, input yRowPkg::rowAddr d,
      input yRowPkg::rowAddr n, input yRowPkg::slotOneHot ds,
      input yRowPkg::slotOneHot ns, input yRowPkg::yEntry dv, input yRowPkg::yEntry cv);
      @(negedge clock);
      dpDone = 1'b1;
      cpDone = second;   // set 2 also starts the write-back
      diagAddr = d;
      nonDiagAddr = n;
      diagSlot = ds;
      nonDiagSlot = ns;
      computedDiag = dv;
      changeData = cv;
      expectSet(d, n, ds, ns, dv, cv, second);
   endtask

   task automatic randomSet(input bit second);
      yRowPkg::rowAddr d;
      d = randAddr();
      applySet(second, d, ($urandom % 2) ? d : randAddr(), randSlot(), randSlot(),
         randEntry(), randEntry());
   endtask

   // optional done flags while busy and a wait for the last write
   task automatic finishPair(input bit busy);
      int pulsesBefore;
      pulsesBefore = donePulses;
      @(negedge clock);
      dpDone = busy;
      cpDone = busy && ($urandom % 2);
      diagAddr = randAddr();
      diagSlot = randSlot();
      @(negedge clock);
      dpDone = 1'b0;
      cpDone = 1'b0;
      while (expAddr.size() != 0)
         @(negedge clock);
      if (donePulses != pulsesBefore + 1)
      begin
         $display("expected one writeDone pulse for the pair, saw %0d",
            donePulses - pulsesBefore);
         otherErrors++;
      end
   endtask

   initial
   begin
      void'($urandom(32'h8a10a78f));
      reset = 1'b0;
      dpDone = 1'b0;
      cpDone = 1'b0;
      diagAddr = '0;
      nonDiagAddr = '0;
      diagSlot = '0;
      nonDiagSlot = '0;
      computedDiag = '0;
      changeData = '0;
      readData1 = '0;
      readData2 = '0;
      for (int a = 0; a < (1 << `ADDR_BITS); a++)
      begin
         mem[a] = fillRow(a);
         shadow[a] = fillRow(a);
      end
      repeat (8) @(posedge clock);
      @(negedge clock);
      reset = 1'b1;
      repeat (4)   // idle unit stays quiet
      begin
         @(negedge clock);
         checkFlag("writeEnable", writeEnable, 1'b0);
         checkFlag("writeDone", writeDone, 1'b0);
         checkAddr("readAddr1", readAddr1, parked);
         checkAddr("readAddr2", readAddr2, parked);
         checkAddr("writeAddr", writeAddr, parked);
      end
      applySet(1'b0, 11'd10, 11'd10, 4'b0001, 4'b0100, randEntry(), randEntry());
      applySet(1'b1, 11'd20, 11'd20, 4'b1000, 4'b0010, randEntry(), randEntry());
      finishPair(1'b0);
      applySet(1'b0, 11'd30, 11'd31, 4'b0010, 4'b0010, randEntry(), randEntry());
      applySet(1'b1, 11'd40, 11'd41, 4'b0100, 4'b0001, randEntry(), randEntry());
      finishPair(1'b0);
      applySet(1'b0, 11'd50, 11'd50, 4'b0010, 4'b0010, randEntry(), randEntry());
      applySet(1'b1, 11'd60, 11'd61, 4'b0000, 4'b0001, randEntry(), randEntry());
      finishPair(1'b0);
      applySet(1'b0, 11'd70, 11'd70, 4'b0011, 4'b0100, randEntry(), randEntry());
      applySet(1'b1, 11'd70, 11'd70, 4'b0001, 4'b1000, randEntry(), randEntry());
      finishPair(1'b0);
      for (int t = 0; t < randomPairs; t++)
      begin
         randomSet(1'b0);
         randomSet(1'b1);
         finishPair(1'b1);
      end
      repeat (5) @(negedge clock);
      $display("value errors %0d, other errors %0d, assertion errors %0d",
         valueErrors, otherErrors, dut0.chk0.failures);
      if (valueErrors + otherErrors + dut0.chk0.failures == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+include
rtl/yRowPkg.sv
rtl/yCtrlPkg.sv
rtl/updateIf.sv
rtl/updateDecode.sv
rtl/writeBackSequencer.sv
rtl/rowMerge.sv
rtl/yWriteBack.sv
verification/yWriteBack_chk.sv
verification/yWriteBackTb.sv
